//--- verilog/fox_pkg.sv
package fox_pkg;

    localparam  int     STEP_CYCLES = 4;        // clocks per executed instruction
    localparam  int     SCAN_CYCLES = 16;       // clocks each digit stays lit
    localparam  int     ROM_WORDS   = 64;       // instruction rom depth

    localparam  logic   [6 : 0]     OPC_LUI     = 7'b0110111;
    localparam  logic   [6 : 0]     OPC_OP_IMM  = 7'b0010011;
    localparam  logic   [6 : 0]     OPC_OP      = 7'b0110011;
    localparam  logic   [6 : 0]     OPC_BRANCH  = 7'b1100011;

    localparam  logic   [2 : 0]     F3_ADD      = 3'b000;   // add, sub, addi
    localparam  logic   [2 : 0]     F3_OR       = 3'b110;
    localparam  logic   [2 : 0]     F3_AND      = 3'b111;
    localparam  logic   [2 : 0]     F3_BEQ      = 3'b000;
    localparam  logic   [2 : 0]     F3_BNE      = 3'b001;

    localparam  logic   [31 : 0]    INSTR_HALT  = 32'h0000_0063;    // beq x0, x0, 0

    typedef struct packed {
        logic   [6 : 0]     funct7;     // bit 5 picks sub
        logic   [4 : 0]     rs2;
        logic   [4 : 0]     rs1;
        logic   [2 : 0]     funct3;
        logic   [4 : 0]     rd;
        logic   [6 : 0]     opcode;
    } r_fmt_t;

    typedef struct packed {
        logic   [11 : 0]    imm11_0;    // sign extended
        logic   [4  : 0]    rs1;
        logic   [2  : 0]    funct3;
        logic   [4  : 0]    rd;
        logic   [6  : 0]    opcode;
    } i_fmt_t;

    typedef struct packed {
        logic   [0 : 0]     imm12;      // sign bit of offset
        logic   [5 : 0]     imm10_5;
        logic   [4 : 0]     rs2;
        logic   [4 : 0]     rs1;
        logic   [2 : 0]     funct3;
        logic   [3 : 0]     imm4_1;
        logic   [0 : 0]     imm11;
        logic   [6 : 0]     opcode;
    } b_fmt_t;

    typedef struct packed {
        logic   [19 : 0]    imm31_12;   // upper immediate
        logic   [4  : 0]    rd;
        logic   [6  : 0]    opcode;
    } u_fmt_t;

    // one instruction word seen through each format
    typedef union packed {
        r_fmt_t     r;
        i_fmt_t     i;
        b_fmt_t     b;
        u_fmt_t     u;
    } instr_u;

    typedef logic   [7 : 0]     seg_code_t;     // {dp, g, f, e, d, c, b, a}, active low

    localparam  seg_code_t  SEG_OFF = 8'hff;    // all segments dark

    // hex glyphs 0 to F, dp off
    localparam  seg_code_t  SEG_HEX [0 : 15] = '{
        8'hc0, 8'hf9, 8'ha4, 8'hb0,
        8'h99, 8'h92, 8'h82, 8'hf8,
        8'h80, 8'h90, 8'h88, 8'h83,
        8'hc6, 8'ha1, 8'h86, 8'h8e
    };

endpackage : fox_pkg

//--- verilog/fox_regfile.sv
`timescale 1ns/1ps

module fox_regfile
(
    input   logic   [0  : 0]    clk,        // clock
    input   logic   [0  : 0]    rst_n,      // reset
    input   logic   [4  : 0]    ra1,        // read address 1
    input   logic   [4  : 0]    ra2,        // read address 2
    output  logic   [31 : 0]    rd1,        // read data 1
    output  logic   [31 : 0]    rd2,        // read data 2
    input   logic   [4  : 0]    wa,         // write address
    input   logic   [31 : 0]    wd,         // write data
    input   logic   [0  : 0]    we,         // write enable
    input   logic   [4  : 0]    scan_addr,  // debug scan address
    output  logic   [31 : 0]    scan_data   // debug scan data
);

    logic   [31 : 0]    regs [1 : 31];      // x0 has no storage

    // x0 reads as zero on every port
    assign rd1       = ( ra1 == 5'd0 )       ? '0 : regs[ra1];
    assign rd2       = ( ra2 == 5'd0 )       ? '0 : regs[ra2];
    assign scan_data = ( scan_addr == 5'd0 ) ? '0 : regs[scan_addr];

    always_ff @(posedge clk, negedge rst_n)
    begin
        if( !rst_n )
        begin
            for( int i = 1; i < 32; i++ )
                regs[i] <= '0;
        end
        else if( we && ( wa != 5'd0 ) )   // writes to x0 dropped
            regs[wa] <= wd;
    end

endmodule : fox_regfile

//--- verilog/fox_instr_rom.sv
`timescale 1ns/1ps

module fox_instr_rom
(
    input   logic   [5 : 0]     addr,       // word address
    output  fox_pkg::instr_u    instr       // instruction word
);

    import fox_pkg::*;

    logic   [31 : 0]    mem [0 : ROM_WORDS-1];

    initial
    begin
        // words past the end of the program spin in place
        for( int i = 0; i < ROM_WORDS; i++ )
            mem[i] = INSTR_HALT;
        $readmemh("program.hex", mem);
    end

    assign instr = mem[addr];   // zero latency read

endmodule : fox_instr_rom

//--- verilog/fox_core.sv
`timescale 1ns/1ps

module fox_core
(
    input   logic   [0  : 0]    clk,        // clock
    input   logic   [0  : 0]    rst_n,      // reset
    output  logic   [5  : 0]    imem_addr,  // rom word address
    input   fox_pkg::instr_u    instr,      // fetched instruction
    output  logic   [4  : 0]    ra1,        // rs1 address
    output  logic   [4  : 0]    ra2,        // rs2 address
    input   logic   [31 : 0]    rd1,        // rs1 value
    input   logic   [31 : 0]    rd2,        // rs2 value
    output  logic   [4  : 0]    wa,         // rd address
    output  logic   [31 : 0]    wd,         // rd value
    output  logic   [0  : 0]    we,         // rd write enable
    output  logic   [31 : 0]    pc          // program counter
);

    import fox_pkg::*;

    logic   [$clog2(STEP_CYCLES)-1 : 0]     step_cnt;   // clock divider
    logic   [0  : 0]    step;           // execute strobe
    logic   [6  : 0]    opcode;
    logic   [2  : 0]    funct3;
    logic   [31 : 0]    imm_i;          // addi immediate
    logic   [31 : 0]    imm_b;          // branch offset
    logic   [31 : 0]    imm_u;          // lui immediate
    logic   [31 : 0]    alu_b;          // second alu operand
    logic   [31 : 0]    alu_res;
    logic   [0  : 0]    is_sub;
    logic   [0  : 0]    writes_rd;      // alu or lui
    logic   [0  : 0]    take_branch;

    assign step      = ( step_cnt == STEP_CYCLES - 1 );
    assign imem_addr = pc[7 : 2];   // word aligned

    // fields shared by every format
    assign opcode = instr.r.opcode;
    assign funct3 = instr.r.funct3;
    assign ra1    = instr.r.rs1;
    assign ra2    = instr.r.rs2;
    assign wa     = instr.r.rd;

    // immediates through their own views
    assign imm_i = { { 20 { instr.i.imm11_0[11] } }, instr.i.imm11_0 };
    assign imm_b = { { 20 { instr.b.imm12 } }, instr.b.imm11,
                     instr.b.imm10_5, instr.b.imm4_1, 1'b0 };
    assign imm_u = { instr.u.imm31_12, 12'h000 };

    // funct7 only meaningful for register ops
    assign is_sub = ( opcode == OPC_OP ) && instr.r.funct7[5];
    assign alu_b  = ( opcode == OPC_OP ) ? rd2 : imm_i;

    always_comb
    begin
        case( funct3 )
            F3_ADD  : alu_res = is_sub ? rd1 - alu_b : rd1 + alu_b;
            F3_OR   : alu_res = rd1 | alu_b;
            F3_AND  : alu_res = rd1 & alu_b;
            default : alu_res = rd1 + alu_b;    // unsupported funct3
        endcase
    end

    always_comb
    begin
        take_branch = 1'b0;
        if( opcode == OPC_BRANCH )
        begin
            case( funct3 )
                F3_BEQ  : take_branch = ( rd1 == rd2 );
                F3_BNE  : take_branch = ( rd1 != rd2 );
                default : take_branch = 1'b0;
            endcase
        end
    end

    assign writes_rd = ( opcode == OPC_OP ) || ( opcode == OPC_OP_IMM ) ||
                       ( opcode == OPC_LUI );
    assign we = step && writes_rd;                  // one write per step
    assign wd = ( opcode == OPC_LUI ) ? imm_u : alu_res;

    // step divider
    always_ff @(posedge clk, negedge rst_n)
    begin
        if( !rst_n )
            step_cnt <= '0;
        else if( step )
            step_cnt <= '0;
        else
            step_cnt <= step_cnt + 1'b1;
    end

    // pc moves on the same edge as the register write
    always_ff @(posedge clk, negedge rst_n)
    begin
        if( !rst_n )
            pc <= '0;
        else if( step )
            pc <= take_branch ? pc + imm_b : pc + 32'd4;
    end

endmodule : fox_core

//--- verilog/seven_seg_dynamic.sv
`timescale 1ns/1ps

module seven_seg_dynamic
(
    input   logic   [0  : 0]    clk,        // clock
    input   logic   [0  : 0]    rst_n,      // reset
    input   logic   [15 : 0]    hex,        // four nibbles to show
    output  fox_pkg::seg_code_t seven_seg,  // segments, active low
    output  logic   [3  : 0]    dig         // digit selects, active low
);

    import fox_pkg::*;

    logic   [$clog2(SCAN_CYCLES)-1 : 0]     hold_cnt;   // cycles on current digit
    logic   [1 : 0]     dig_idx;        // digit being scanned
    logic   [3 : 0]     nibble;         // value for that digit

    // digit 0 is the low nibble
    always_comb
    begin
        case( dig_idx )
            2'd0    : nibble = hex[3  : 0 ];
            2'd1    : nibble = hex[7  : 4 ];
            2'd2    : nibble = hex[11 : 8 ];
            default : nibble = hex[15 : 12];
        endcase
    end

    // scan counter, wraps 3 -> 0
    always_ff @(posedge clk, negedge rst_n)
    begin
        if( !rst_n )
        begin
            hold_cnt <= '0;
            dig_idx  <= '0;
        end
        else if( hold_cnt == SCAN_CYCLES - 1 )
        begin
            hold_cnt <= '0;
            dig_idx  <= dig_idx + 1'b1;
        end
        else
            hold_cnt <= hold_cnt + 1'b1;
    end

    // select and glyph leave on the same edge
    always_ff @(posedge clk, negedge rst_n)
    begin
        if( !rst_n )
        begin
            dig       <= '1;        // all digits dark
            seven_seg <= SEG_OFF;
        end
        else
        begin
            dig       <= ~( 4'b0001 << dig_idx );
            seven_seg <= SEG_HEX[nibble];
        end
    end

endmodule : seven_seg_dynamic

//--- verilog/fox_board_top.sv
`timescale 1ns/1ps

module fox_board_top
(
    input   logic   [0 : 0]     clk50mhz,   // board clock
    input   logic   [0 : 0]     rst_n,      // reset key
    input   logic   [3 : 0]     key,        // register select
    output  logic   [3 : 0]     led,        // pc word index
    output  fox_pkg::seg_code_t hex0,       // segments
    output  logic   [3 : 0]     dig         // digit selects
);

    fox_pkg::instr_u    instr;          // rom to core
    logic   [5  : 0]    imem_addr;
    logic   [4  : 0]    ra1;
    logic   [4  : 0]    ra2;
    logic   [31 : 0]    rd1;
    logic   [31 : 0]    rd2;
    logic   [4  : 0]    wa;
    logic   [31 : 0]    wd;
    logic   [0  : 0]    we;
    logic   [31 : 0]    pc;
    logic   [31 : 0]    scan_data;      // register picked by keys

    assign led = pc[5 : 2];

    fox_core
    fox_core_0
    (
        .clk        ( clk50mhz  ),
        .rst_n      ( rst_n     ),
        .imem_addr  ( imem_addr ),
        .instr      ( instr     ),
        .ra1        ( ra1       ),
        .ra2        ( ra2       ),
        .rd1        ( rd1       ),
        .rd2        ( rd2       ),
        .wa         ( wa        ),
        .wd         ( wd        ),
        .we         ( we        ),
        .pc         ( pc        )
    );

    fox_instr_rom
    fox_instr_rom_0
    (
        .addr       ( imem_addr ),
        .instr      ( instr     )
    );

    fox_regfile
    fox_regfile_0
    (
        .clk        ( clk50mhz          ),
        .rst_n      ( rst_n             ),
        .ra1        ( ra1               ),
        .ra2        ( ra2               ),
        .rd1        ( rd1               ),
        .rd2        ( rd2               ),
        .wa         ( wa                ),
        .wd         ( wd                ),
        .we         ( we                ),
        .scan_addr  ( { 1'b0, key }     ),  // x0 to x15 only
        .scan_data  ( scan_data         )
    );

    seven_seg_dynamic
    seven_seg_dynamic_0
    (
        .clk        ( clk50mhz          ),
        .rst_n      ( rst_n             ),
        .hex        ( scan_data[15 : 0] ),  // low half shown
        .seven_seg  ( hex0              ),
        .dig        ( dig               )
    );

endmodule : fox_board_top

//--- verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
(
    output  logic   [0 : 0]     clk,        // 100 ns period
    output  logic   [0 : 0]     rst_n,      // reset, active low
    input   logic   [0 : 0]     reset_req   // rising edge starts another reset
);

    initial
    begin
        clk = 1'b0;
        forever
            #50 clk = ~clk;             // half period
    end

    initial
    begin
        rst_n = 1'b0;                   // power-on reset
        repeat( 8 ) @(posedge clk);
        #1 rst_n = 1'b1;                // release clear of the edge
        forever
        begin
            @(posedge reset_req);
            rst_n = 1'b0;
            repeat( 8 ) @(posedge clk);
            #1 rst_n = 1'b1;
        end
    end

endmodule : tb_clock

//--- verification/tb_fox_board_top.sv
`timescale 1ns/1ps

module tb_fox_board_top;

    import fox_pkg::*;

    logic   [0  : 0]    clk50mhz;
    logic   [0  : 0]    rst_n;
    logic   [0  : 0]    reset_req;          // asks for a reset mid-run
    logic   [3  : 0]    key;
    logic   [3  : 0]    led;
    seg_code_t          hex0;
    logic   [3  : 0]    dig;

    logic   [31 : 0]    prog [0 : ROM_WORDS-1];     // model copy of the program
    logic   [31 : 0]    model_regs [0 : 31];        // expected register values
    logic   [31 : 0]    halt_pc;                    // pc of the branch-to-self
    logic   [31 : 0]    key_val;
    int                 halt_steps;                 // steps until the halt
    int                 key_tests;
    int                 limit_cycles = 0;           // watchdog budget
    int                 tests = 0;
    int                 checks = 0;
    int                 errors = 0;
    int                 errors_seen = 0;            // errors at the last test end
    integer             seed = 30;

    tb_clock clock_gen ( .clk( clk50mhz ), .rst_n( rst_n ), .reset_req( reset_req ) );

    fox_board_top DUT
    (
        .clk50mhz   ( clk50mhz  ),
        .rst_n      ( rst_n     ),
        .key        ( key       ),
        .led        ( led       ),
        .hex0       ( hex0      ),
        .dig        ( dig       )
    );

    task automatic report_failure(input string msg);
        errors++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic check_seg(input seg_code_t got, input seg_code_t exp);
        checks++;
        if( got !== exp )
        begin
            errors++;
            $display("FAIL %0t hex0 got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_nibble(input string name, input logic [3 : 0] got,
                                input logic [3 : 0] exp);
        checks++;
        if( got !== exp )
        begin
            errors++;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_led(input logic [3 : 0] got, input logic [3 : 0] exp);
        checks++;
        if( got !== exp )
        begin
            errors++;
            $display("FAIL %0t led got %h expected %h", $time, got, exp);
        end
    endtask

    task automatic check_dig(input logic [3 : 0] got, input logic [3 : 0] exp);
        checks++;
        if( got !== exp )
        begin
            errors++;
            $display("FAIL %0t dig got %b expected %b", $time, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        if( errors == errors_seen )
            $display("test %0d %s: ok", tests, name);
        else
            $display("test %0d %s: %0d errors", tests, name, errors - errors_seen);
        errors_seen = errors;
    endtask

    function automatic logic [31 : 0] alu_model(input logic [2 : 0] f3, input logic sub,
                                                input logic [31 : 0] a, input logic [31 : 0] b);
        case( f3 )
            F3_OR   : return a | b;
            F3_AND  : return a & b;
            default : return sub ? a - b : a + b;   // add, sub, addi
        endcase
    endfunction

    // ISA interpreter that stops on a branch to itself
    task automatic run_model();
        logic   [31 : 0]    pc;
        logic   [31 : 0]    w;
        logic   [31 : 0]    a;
        logic   [31 : 0]    b;
        logic   [31 : 0]    res;
        logic   [31 : 0]    next_pc;
        logic               wr;
        logic               done;
        $readmemh("program.hex", prog);
        for( int r = 0; r < 32; r++ )
            model_regs[r] = '0;
        pc         = '0;
        done       = 1'b0;
        halt_steps = 0;
        while( !done && halt_steps < 1000 )
        begin
            w       = prog[pc[7 : 2]];
            a       = model_regs[w[19 : 15]];
            b       = model_regs[w[24 : 20]];
            wr      = 1'b1;
            res     = '0;
            next_pc = pc + 32'd4;
            case( w[6 : 0] )
                OPC_LUI    : res = { w[31 : 12], 12'h000 };
                OPC_OP_IMM :
                    res = alu_model(w[14 : 12], 1'b0, a, { { 20 { w[31] } }, w[31 : 20] });
                OPC_OP     : res = alu_model(w[14 : 12], w[30], a, b);     // bit 30 is funct7[5]
                OPC_BRANCH :
                begin
                    wr = 1'b0;
                    if( ( w[14 : 12] == F3_BEQ && a == b ) ||
                        ( w[14 : 12] == F3_BNE && a != b ) )
                        next_pc = pc + { { 20 { w[31] } }, w[7], w[30 : 25],
                                         w[11 : 8], 1'b0 };
                end
                default    : wr = 1'b0;
            endcase
            if( wr && w[11 : 7] != 5'd0 )
                model_regs[w[11 : 7]] = res;    // x0 stays zero
            if( next_pc == pc )
                done = 1'b1;
            else
            begin
                pc = next_pc;
                halt_steps++;
            end
        end
        halt_pc = pc;
        if( !done )
            report_failure("model never reached a branch-to-self");
    endtask

    // bit 4 marks a known glyph
    function automatic logic [4 : 0] decode_seg(input seg_code_t s);
        case( s )                           // standard active-low hex glyphs
            8'hc0   : return 5'h10;
            8'hf9   : return 5'h11;
            8'ha4   : return 5'h12;
            8'hb0   : return 5'h13;
            8'h99   : return 5'h14;
            8'h92   : return 5'h15;
            8'h82   : return 5'h16;
            8'hf8   : return 5'h17;
            8'h80   : return 5'h18;
            8'h90   : return 5'h19;
            8'h88   : return 5'h1a;
            8'h83   : return 5'h1b;
            8'hc6   : return 5'h1c;
            8'ha1   : return 5'h1d;
            8'h86   : return 5'h1e;
            8'h8e   : return 5'h1f;
            default : return 5'h00;         // no hex glyph
        endcase
    endfunction

    function automatic int lit_digit(input logic [3 : 0] d);
        case( d )
            4'b1110 : return 0;
            4'b1101 : return 1;
            4'b1011 : return 2;
            4'b0111 : return 3;
            default : return -1;            // none or several lit
        endcase
    endfunction

    task automatic set_key(input logic [3 : 0] k);
        @(posedge clk50mhz);
        #1 key = k;
    endtask

    task automatic pulse_reset();
        @(posedge clk50mhz);
        #1 reset_req = 1'b1;
        @(posedge clk50mhz);
        #1 reset_req = 1'b0;
    endtask

    task automatic check_reset_state();
        repeat( 4 ) @(negedge clk50mhz);    // still inside the 8 reset cycles
        check_dig(dig, 4'b1111);
        check_led(led, 4'h0);
        check_seg(hex0, SEG_OFF);
    endtask

    task automatic wait_program();
        repeat( ( halt_steps + 1 ) * STEP_CYCLES ) @(posedge clk50mhz);
    endtask

    task automatic check_halt();
        for( int n = 0; n < 8; n++ )
        begin
            repeat( STEP_CYCLES ) @(negedge clk50mhz);
            check_led(led, halt_pc[5 : 2]);
        end
    endtask

    // one refresh, then one scan of samples
    task automatic show_register(input logic [31 : 0] expected);
        int                 idx;
        logic   [4 : 0]     dec;
        logic   [3 : 0]     seen;
        seen = '0;
        repeat( 4 * SCAN_CYCLES + 1 ) @(posedge clk50mhz);
        repeat( 4 * SCAN_CYCLES )
        begin
            @(negedge clk50mhz);
            idx = lit_digit(dig);
            if( idx < 0 )
                report_failure($sformatf("dig is %b, not exactly one digit lit", dig));
            else
            begin
                seen[idx] = 1'b1;
                dec       = decode_seg(hex0);
                if( !dec[4] )
                    report_failure($sformatf("hex0 pattern %h is no hex glyph", hex0));
                else
                    check_nibble($sformatf("hex0 digit %0d", idx), dec[3 : 0],
                                 expected[idx*4 +: 4]);
            end
        end
        if( seen != 4'hf )
            report_failure("not every digit was lit during one scan");
    endtask

    task automatic read_random_keys(input int n);
        for( int t = 0; t < n; t++ )
        begin
            key_val = $random( seed );
            set_key(key_val[3 : 0]);
            show_register(model_regs[key_val[3 : 0]]);
        end
    endtask

    task automatic check_scan_order();
        int                 waited;
        logic   [3 : 0]     prev;
        logic   [3 : 0]     exp_dig;
        waited = 0;
        @(negedge clk50mhz);
        prev = dig;
        @(negedge clk50mhz);
        // sync on the first sample of digit 0
        while( ( dig != 4'b1110 || prev == 4'b1110 ) && waited < 4 * SCAN_CYCLES + 2 )
        begin
            prev = dig;
            @(negedge clk50mhz);
            waited++;
        end
        if( waited >= 4 * SCAN_CYCLES + 2 )
            report_failure("digit 0 never came back on");
        else
        begin
            for( int k = 1; k <= 4 * SCAN_CYCLES; k++ )   // last sample wraps to digit 0
            begin
                @(negedge clk50mhz);
                exp_dig                            = 4'b1111;
                exp_dig[( k / SCAN_CYCLES ) % 4]   = 1'b0;
                check_dig(dig, exp_dig);
            end
        end
    endtask

    initial
    begin
        key       = 4'h0;
        reset_req = 1'b0;
        key_tests = 20;
        run_model();
        limit_cycles = 2 * ( 2 * ( ( halt_steps + 1 ) * STEP_CYCLES + 16 )
                     + ( 2 * key_tests + 2 ) * ( 8 * SCAN_CYCLES + 4 ) + 64 * STEP_CYCLES );
        check_reset_state();
        end_test("reset state");
        @(posedge rst_n);
        wait_program();
        check_halt();
        end_test("halt pc on led");
        read_random_keys(key_tests);
        end_test("random register reads");
        check_scan_order();
        end_test("digit scan order");
        set_key(4'h0);
        show_register(32'd0);           // x0 despite the write to it
        end_test("x0 reads zero");
        pulse_reset();
        check_reset_state();
        end_test("second reset");
        @(posedge rst_n);
        wait_program();
        check_halt();
        end_test("halt pc after second reset");
        read_random_keys(key_tests);
        end_test("random reads after second reset");
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if( errors == 0 )
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    // watchdog
    initial
    begin
        wait( limit_cycles > 0 );
        repeat( limit_cycles ) @(posedge clk50mhz);
        $display("watchdog: no result after %0d cycles", limit_cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule : tb_fox_board_top

//--- program.hex
// one 32-bit instruction word per line, in hex, from word address 0 upward
// the text after each word is its assembly
123450b7    // lui  x1, 0x12345
67808093    // addi x1, x1, 0x678
fff00113    // addi x2, x0, -1
00500193    // addi x3, x0, 5       loop count
11120213    // addi x4, x4, 0x111   loop body
fff18193    // addi x3, x3, -1
fe019ce3    // bne  x3, x0, -8
004082b3    // add  x5, x1, x4
40228333    // sub  x6, x5, x2
0040f3b3    // and  x7, x1, x4
0040e433    // or   x8, x1, x4
00108033    // add  x0, x1, x1      write to x0 is dropped
abcde4b7    // lui  x9, 0xabcde
edd48493    // addi x9, x9, -0x123
00018463    // beq  x3, x0, +8      taken
7ff00513    // addi x10, x0, 0x7ff  skipped
00208463    // beq  x1, x2, +8      not taken
00000063    // beq  x0, x0, 0       halt

//--- verilog.f
verilog/fox_pkg.sv
verilog/fox_regfile.sv
verilog/fox_instr_rom.sv
verilog/fox_core.sv
verilog/seven_seg_dynamic.sv
verilog/fox_board_top.sv
verification/tb_clock.sv
verification/tb_fox_board_top.sv

//--- Bender.yml
package:
  name: fox_board

sources:
  - verilog/fox_pkg.sv
  - verilog/fox_regfile.sv
  - verilog/fox_instr_rom.sv
  - verilog/fox_core.sv
  - verilog/seven_seg_dynamic.sv
  - verilog/fox_board_top.sv
  - target: test
    files:
      - verification/tb_clock.sv
      - verification/tb_fox_board_top.sv
